// ==== axis_stream_pkg.sv ====
`default_nettype none

package axis_stream_pkg;

	//////////////////////////////////////////////////
	// Stream geometry
	//////////////////////////////////////////////////

	localparam int tdata_width = 32;
	localparam int tstrb_width = tdata_width / 8;

	// Two coefficients share one beat
	localparam int coeffs_per_beat = 2;

	// Input word count of one block
	localparam int beats_per_block = 8;

	typedef logic [tdata_width-1:0] tdata_t;
	typedef logic [tstrb_width-1:0] tstrb_t;
	typedef logic [$clog2(beats_per_block)-1:0] beat_ptr_t;

	// Selects one half of the ping-pong store
	typedef logic bank_t;

endpackage

`default_nettype wire

// ==== daala_4x4_transpose.sv ====
`default_nettype none

module daala_4x4_transpose (
	input  wire                                S_AXIS_ACLK,
	input  wire                                S_AXIS_ARESETN,
	input  wire axis_stream_pkg::tdata_t       s_axis_tdata,
	input  wire axis_stream_pkg::tstrb_t       s_axis_tstrb,
	input  wire                                s_axis_tlast,
	input  wire                                s_axis_tvalid,
	output wire                                s_axis_tready,
	output wire axis_stream_pkg::tdata_t       m_axis_tdata,
	output wire                                m_axis_tlast,
	output wire                                m_axis_tvalid,
	input  wire                                m_axis_tready
);
	import axis_stream_pkg::*;

	// Slave to buffer
	wire            wr_en;
	wire bank_t     wr_bank;
	wire beat_ptr_t wr_ptr;
	wire tdata_t    wr_data;
	wire            block_done;

	// Master to buffer and back
	wire bank_t     rd_bank;
	wire beat_ptr_t rd_ptr;
	wire            rd_release;
	wire tdata_t    rd_data;
	wire [1:0]      bank_full;

	daala_4x4_transpose_s00_axis u_s00_axis (
		.S_AXIS_ACLK    (S_AXIS_ACLK),
		.S_AXIS_ARESETN (S_AXIS_ARESETN),
		.s_axis_tdata   (s_axis_tdata),
		.s_axis_tstrb   (s_axis_tstrb),
		.s_axis_tlast   (s_axis_tlast),
		.s_axis_tvalid  (s_axis_tvalid),
		.s_axis_tready  (s_axis_tready),
		.bank_full      (bank_full),
		.wr_en          (wr_en),
		.wr_bank        (wr_bank),
		.wr_ptr         (wr_ptr),
		.wr_data        (wr_data),
		.block_done     (block_done)
	);

	transpose_block_buffer u_buffer (
		.S_AXIS_ACLK    (S_AXIS_ACLK),
		.S_AXIS_ARESETN (S_AXIS_ARESETN),
		.wr_en          (wr_en),
		.wr_bank        (wr_bank),
		.wr_ptr         (wr_ptr),
		.wr_data        (wr_data),
		.block_done     (block_done),
		.rd_bank        (rd_bank),
		.rd_ptr         (rd_ptr),
		.rd_release     (rd_release),
		.rd_data        (rd_data),
		.bank_full      (bank_full)
	);

	daala_4x4_transpose_m00_axis u_m00_axis (
		.S_AXIS_ACLK    (S_AXIS_ACLK),
		.S_AXIS_ARESETN (S_AXIS_ARESETN),
		.m_axis_tdata   (m_axis_tdata),
		.m_axis_tlast   (m_axis_tlast),
		.m_axis_tvalid  (m_axis_tvalid),
		.m_axis_tready  (m_axis_tready),
		.bank_full      (bank_full),
		.rd_data        (rd_data),
		.rd_bank        (rd_bank),
		.rd_ptr         (rd_ptr),
		.rd_release     (rd_release)
	);

endmodule

`default_nettype wire

// ==== daala_4x4_transpose_m00_axis.sv ====
`default_nettype none

module daala_4x4_transpose_m00_axis (
	input  wire                                S_AXIS_ACLK,
	input  wire                                S_AXIS_ARESETN,
	output axis_stream_pkg::tdata_t            m_axis_tdata,
	output logic                               m_axis_tlast,
	output logic                               m_axis_tvalid,
	input  wire                                m_axis_tready,
	input  wire [1:0]                          bank_full,
	input  wire axis_stream_pkg::tdata_t       rd_data,
	output axis_stream_pkg::bank_t             rd_bank,
	output axis_stream_pkg::beat_ptr_t         rd_ptr,
	output logic                               rd_release
);
	import axis_stream_pkg::*;

	typedef enum logic {
		idle,
		send
	} send_state_t;

	send_state_t state;
	bank_t       bank_sel;
	beat_ptr_t   read_pointer;
	logic        load_beat;

	assign rd_bank = bank_sel;
	assign rd_ptr  = read_pointer;

	// Output register is free when empty or when its beat leaves now,
	// except after the tlast beat, which closes the block
	assign load_beat = (state == send) &&
		(!m_axis_tvalid || (m_axis_tready && !m_axis_tlast));

	// Eighth transfer hands the bank back to the slave
	assign rd_release = m_axis_tvalid && m_axis_tready && m_axis_tlast;

	//////////////////////////////////////////////////
	// Send FSM
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			state         <= idle;
			bank_sel      <= '0;
			read_pointer  <= '0;
			m_axis_tvalid <= 1'b0;
			m_axis_tlast  <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
				begin
					// Banks are drained in the order they were filled
					if (bank_full[bank_sel])
						state <= send;
				end
				send:
				begin
					if (rd_release)
					begin
						state         <= idle;
						bank_sel      <= ~bank_sel;
						m_axis_tvalid <= 1'b0;
						m_axis_tlast  <= 1'b0;
					end
					else if (load_beat)
					begin
						m_axis_tvalid <= 1'b1;
						m_axis_tlast  <= (read_pointer == beat_ptr_t'(beats_per_block - 1));
						read_pointer  <= read_pointer + beat_ptr_t'(1);
					end
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (load_beat)
			m_axis_tdata <= rd_data;
	end

	// A stalled beat is held until it transfers
	assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		(m_axis_tvalid && !m_axis_tready) |=>
			(m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)));

endmodule

`default_nettype wire

// ==== daala_4x4_transpose_s00_axis.sv ====
`default_nettype none

module daala_4x4_transpose_s00_axis (
	input  wire                                S_AXIS_ACLK,
	input  wire                                S_AXIS_ARESETN,
	input  wire axis_stream_pkg::tdata_t       s_axis_tdata,
	input  wire axis_stream_pkg::tstrb_t       s_axis_tstrb,
	input  wire                                s_axis_tlast,
	input  wire                                s_axis_tvalid,
	output logic                               s_axis_tready,
	input  wire [1:0]                          bank_full,
	output logic                               wr_en,
	output axis_stream_pkg::bank_t             wr_bank,
	output axis_stream_pkg::beat_ptr_t         wr_ptr,
	output axis_stream_pkg::tdata_t            wr_data,
	output logic                               block_done
);
	import axis_stream_pkg::*;

	typedef enum logic [1:0] {
		idle,
		write,
		pad
	} capture_state_t;

	capture_state_t state;
	beat_ptr_t      write_pointer;
	bank_t          bank_sel;
	tdata_t         strobed_data;
	logic           beat_accept;
	logic           last_slot;

	//////////////////////////////////////////////////
	// Handshake
	//////////////////////////////////////////////////

	// Ready only in write and only while the target bank is free
	assign s_axis_tready = (state == write) && !bank_full[bank_sel];
	assign beat_accept   = s_axis_tvalid && s_axis_tready;
	assign last_slot     = (write_pointer == beat_ptr_t'(beats_per_block - 1));

	// Bytes without strobe are stored as zero
	always_comb
	begin
		for (int b = 0; b < tstrb_width; b++)
		begin
			strobed_data[b*8 +: 8] = s_axis_tstrb[b] ? s_axis_tdata[b*8 +: 8] : 8'h00;
		end
	end

	//////////////////////////////////////////////////
	// Buffer write port
	//////////////////////////////////////////////////

	// Pad state writes one zero beat per cycle
	assign wr_en      = beat_accept || (state == pad);
	assign wr_bank    = bank_sel;
	assign wr_ptr     = write_pointer;
	assign wr_data    = (state == pad) ? '0 : strobed_data;
	assign block_done = wr_en && last_slot;

	//////////////////////////////////////////////////
	// Capture FSM
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			state         <= idle;
			write_pointer <= '0;
			bank_sel      <= '0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (s_axis_tvalid)
						state <= write;
				end
				write:
				begin
					if (beat_accept)
					begin
						write_pointer <= write_pointer + beat_ptr_t'(1);
						if (last_slot)
							state <= idle;
						else if (s_axis_tlast)
							state <= pad;
					end
				end
				pad:
				begin
					write_pointer <= write_pointer + beat_ptr_t'(1);
					if (last_slot)
						state <= idle;
				end
				default:
				begin
					state <= idle;
				end
			endcase

			// Next block goes to the other bank
			if (block_done)
				bank_sel <= ~bank_sel;
		end
	end

	// Buffer must never be overwritten before the master frees it
	assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		wr_en |-> !bank_full[wr_bank]);

endmodule

`default_nettype wire

// ==== daala_block_pkg.sv ====
`default_nettype none

package daala_block_pkg;

	//////////////////////////////////////////////////
	// Block geometry
	//////////////////////////////////////////////////

	// Bits in one transform coefficient
	localparam int coeff_width = 16;

	// Rows and columns of a square block
	localparam int block_dim = 4;

	localparam int coeffs_per_block = block_dim * block_dim;

	//////////////////////////////////////////////////
	// Coefficient types
	//////////////////////////////////////////////////

	// One signed coefficient, carried as raw bits
	typedef logic [coeff_width-1:0] coeff_t;

	// Position inside a block: row * block_dim + column
	typedef logic [$clog2(coeffs_per_block)-1:0] coeff_index_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_daala_4x4_transpose -f sources.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== sources.f ====
daala_block_pkg.sv
axis_stream_pkg.sv
daala_4x4_transpose_s00_axis.sv
transpose_block_buffer.sv
daala_4x4_transpose_m00_axis.sv
daala_4x4_transpose.sv
transpose_checker.sv
tb_daala_4x4_transpose.sv

// ==== tb_daala_4x4_transpose.sv ====
`default_nettype none

module tb_daala_4x4_transpose;
	import axis_stream_pkg::*;

	localparam int full_blocks    = 4;
	localparam int strobe_blocks  = 4;
	localparam int early_blocks   = 3;
	localparam int stall_blocks   = 24;
	localparam int gap_blocks     = 16;
	localparam int total_beats    = beats_per_block *
		(full_blocks + strobe_blocks + early_blocks + stall_blocks + gap_blocks);
	localparam int timeout_cycles = 8 * total_beats + 200;

	logic        S_AXIS_ACLK;
	logic        S_AXIS_ARESETN;
	tdata_t      s_axis_tdata;
	tstrb_t      s_axis_tstrb;
	logic        s_axis_tlast;
	logic        s_axis_tvalid;
	wire         s_axis_tready;
	wire tdata_t m_axis_tdata;
	wire         m_axis_tlast;
	wire         m_axis_tvalid;
	logic        m_axis_tready;
	logic [2:0]  test_id;
	logic        test_end;
	wire         drained;
	int          pass_count;
	int          fail_count;
	logic [31:0] lfsr_state;
	logic [1:0]  stall_level;
	int          cycle_count = 0;

	daala_4x4_transpose UUT (
		.S_AXIS_ACLK    (S_AXIS_ACLK),
		.S_AXIS_ARESETN (S_AXIS_ARESETN),
		.s_axis_tdata   (s_axis_tdata),
		.s_axis_tstrb   (s_axis_tstrb),
		.s_axis_tlast   (s_axis_tlast),
		.s_axis_tvalid  (s_axis_tvalid),
		.s_axis_tready  (s_axis_tready),
		.m_axis_tdata   (m_axis_tdata),
		.m_axis_tlast   (m_axis_tlast),
		.m_axis_tvalid  (m_axis_tvalid),
		.m_axis_tready  (m_axis_tready)
	);

	transpose_checker u_checker (
		.S_AXIS_ACLK    (S_AXIS_ACLK),
		.S_AXIS_ARESETN (S_AXIS_ARESETN),
		.s_axis_tdata   (s_axis_tdata),
		.s_axis_tstrb   (s_axis_tstrb),
		.s_axis_tlast   (s_axis_tlast),
		.s_axis_tvalid  (s_axis_tvalid),
		.s_axis_tready  (s_axis_tready),
		.m_axis_tdata   (m_axis_tdata),
		.m_axis_tlast   (m_axis_tlast),
		.m_axis_tvalid  (m_axis_tvalid),
		.m_axis_tready  (m_axis_tready),
		.test_id        (test_id),
		.test_end       (test_end),
		.drained        (drained),
		.pass_count     (pass_count),
		.fail_count     (fail_count)
	);

	initial
	begin
		S_AXIS_ACLK = 1'b0;
		forever
			#20 S_AXIS_ACLK = ~S_AXIS_ACLK;
	end

	always @(posedge S_AXIS_ACLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Timeout after %0d cycles, the DUT stopped moving blocks", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// Every input change happens here, 2 units past the edge
	task automatic next_cycle();
		logic [31:0] r;
		@(posedge S_AXIS_ACLK);
		#2;
		if (stall_level == 2'd0)
			m_axis_tready = 1'b1;
		else
		begin
			random_bits(2, r);
			m_axis_tready = (r[1:0] >= stall_level);
		end
	endtask

	task automatic send_beat(input tdata_t data, input tstrb_t strb, input logic last);
		logic accepted;
		accepted = 1'b0;
		s_axis_tdata = data;
		s_axis_tstrb = strb;
		s_axis_tlast = last;
		s_axis_tvalid = 1'b1;
		while (!accepted)
		begin
			@(negedge S_AXIS_ACLK);
			accepted = s_axis_tready;
			next_cycle();
		end
		s_axis_tvalid = 1'b0;
	endtask

	task automatic send_block(input int beats, input logic mark_last, input logic rand_strobe,
		input logic rand_gaps);
		logic [31:0] data;
		logic [31:0] strb;
		logic [31:0] gap;
		for (int k = 0; k < beats; k++)
		begin
			if (rand_gaps)
			begin
				random_bits(2, gap);
				if (gap[1:0] == 2'b00)
					next_cycle();
			end
			random_bits(32, data);
			strb = 32'hf;
			if (rand_strobe)
				random_bits(4, strb);
			send_beat(data, tstrb_t'(strb), mark_last && (k == beats - 1));
		end
	endtask

	task automatic finish_test();
		while (!drained)
			next_cycle();
		test_end = 1'b1;
		next_cycle();
		test_end = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		lfsr_state = 32'hde2c_e859;
		S_AXIS_ARESETN = 1'b0;
		s_axis_tdata = '0;
		s_axis_tstrb = '0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b0;
		test_id = 3'd0;
		test_end = 1'b0;
		stall_level = 2'd0;
		repeat (3) @(posedge S_AXIS_ACLK);
		#2;
		S_AXIS_ARESETN = 1'b1;

		repeat (10) next_cycle();
		finish_test();

		test_id = 3'd1;
		for (int b = 0; b < full_blocks; b++)
			send_block(beats_per_block, 1'b1, 1'b0, 1'b0);
		finish_test();

		test_id = 3'd2;
		for (int b = 0; b < strobe_blocks; b++)
			send_block(beats_per_block, 1'b1, 1'b1, 1'b0);
		finish_test();

		// Early tlast after 1, 3 and 6 beats
		test_id = 3'd3;
		send_block(1, 1'b1, 1'b0, 1'b0);
		send_block(3, 1'b1, 1'b0, 1'b0);
		send_block(6, 1'b1, 1'b0, 1'b0);
		finish_test();

		// No tlast here, blocks close on the beat count
		test_id = 3'd4;
		stall_level = 2'd2;
		for (int b = 0; b < stall_blocks; b++)
			send_block(beats_per_block, 1'b0, 1'b0, 1'b0);
		finish_test();

		test_id = 3'd5;
		stall_level = 2'd1;
		for (int b = 0; b < gap_blocks; b++)
			send_block(beats_per_block, 1'b1, 1'b1, 1'b1);
		finish_test();

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && pass_count == 6)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== transpose_block_buffer.sv ====
`default_nettype none

module transpose_block_buffer (
	input  wire                                S_AXIS_ACLK,
	input  wire                                S_AXIS_ARESETN,
	input  wire                                wr_en,
	input  wire axis_stream_pkg::bank_t        wr_bank,
	input  wire axis_stream_pkg::beat_ptr_t    wr_ptr,
	input  wire axis_stream_pkg::tdata_t       wr_data,
	input  wire                                block_done,
	input  wire axis_stream_pkg::bank_t        rd_bank,
	input  wire axis_stream_pkg::beat_ptr_t    rd_ptr,
	input  wire                                rd_release,
	output axis_stream_pkg::tdata_t            rd_data,
	output logic [1:0]                         bank_full
);
	import daala_block_pkg::*;
	import axis_stream_pkg::*;

	coeff_t coeff_mem [0:1][0:coeffs_per_block-1];

	//////////////////////////////////////////////////
	// Index mapping
	//////////////////////////////////////////////////

	// Input beat k holds row-major positions 2k and 2k+1
	function automatic coeff_index_t row_major_index(input beat_ptr_t ptr, input int n);
		return coeff_index_t'(int'(ptr) * coeffs_per_beat + n);
	endfunction

	// Output beat j: column j/2, rows 2*(j mod 2) and the one below
	function automatic coeff_index_t col_major_index(input beat_ptr_t ptr, input int n);
		int beats_per_col;
		int row;
		int col;
		beats_per_col = block_dim / coeffs_per_beat;
		col = int'(ptr) / beats_per_col;
		row = (int'(ptr) % beats_per_col) * coeffs_per_beat + n;
		return coeff_index_t'(row * block_dim + col);
	endfunction

	//////////////////////////////////////////////////
	// Coefficient store
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (wr_en)
		begin
			for (int n = 0; n < coeffs_per_beat; n++)
			begin
				coeff_mem[wr_bank][row_major_index(wr_ptr, n)] <=
					wr_data[n*coeff_width +: coeff_width];
			end
		end
	end

	// Read side gathers one column pair, no register
	always_comb
	begin
		for (int n = 0; n < coeffs_per_beat; n++)
		begin
			rd_data[n*coeff_width +: coeff_width] =
				coeff_mem[rd_bank][col_major_index(rd_ptr, n)];
		end
	end

	//////////////////////////////////////////////////
	// Bank ownership
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			bank_full <= '0;
		end
		else
		begin
			for (int b = 0; b < 2; b++)
			begin
				if (block_done && (wr_bank == bank_t'(b)))
					bank_full[b] <= 1'b1;
				else if (rd_release && (rd_bank == bank_t'(b)))
					bank_full[b] <= 1'b0;
			end
		end
	end

	// Slave fills only empty banks, master frees only full ones
	assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		!(block_done && rd_release && (wr_bank == rd_bank)));

endmodule

`default_nettype wire

// ==== transpose_checker.sv ====
`default_nettype none

module transpose_checker (
	input  wire                          S_AXIS_ACLK,
	input  wire                          S_AXIS_ARESETN,
	input  wire axis_stream_pkg::tdata_t s_axis_tdata,
	input  wire axis_stream_pkg::tstrb_t s_axis_tstrb,
	input  wire                          s_axis_tlast,
	input  wire                          s_axis_tvalid,
	input  wire                          s_axis_tready,
	input  wire axis_stream_pkg::tdata_t m_axis_tdata,
	input  wire                          m_axis_tlast,
	input  wire                          m_axis_tvalid,
	input  wire                          m_axis_tready,
	input  wire [2:0]                    test_id,
	input  wire                          test_end,
	output logic                         drained,
	output int                           pass_count,
	output int                           fail_count
);
	import daala_block_pkg::*;
	import axis_stream_pkg::*;

	typedef logic [coeffs_per_block*coeff_width-1:0] block_bits_t;

	tdata_t      expected_q[$];
	tdata_t      expect_data;
	logic        expect_last;
	block_bits_t block_in;
	int          in_beat;
	int          out_beat;
	int          open_blocks;
	int          test_errors;
	int          beats_checked;
	int          backpressure_cycles;

	// Reference transpose: column j/2, rows 2*(j mod 2) and the one below
	function automatic tdata_t transpose_beat(input block_bits_t blk, input int j);
		int col;
		int top;
		col = j / 2;
		top = (j % 2) * 2;
		return {blk[((top + 1) * block_dim + col) * coeff_width +: coeff_width],
			blk[(top * block_dim + col) * coeff_width +: coeff_width]};
	endfunction

	function automatic tdata_t strobe_mask(input tdata_t data, input tstrb_t strb);
		tdata_t masked;
		for (int b = 0; b < tstrb_width; b++)
			masked[b*8 +: 8] = strb[b] ? data[b*8 +: 8] : 8'h00;
		return masked;
	endfunction

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd0: return "reset_idle";
			3'd1: return "full_blocks";
			3'd2: return "strobe_mask";
			3'd3: return "early_tlast";
			3'd4: return "ready_stalls";
			default: return "valid_gaps";
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Mid-cycle sampling, transfers complete on the next edge
	//////////////////////////////////////////////////

	always @(negedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			expected_q.delete();
			block_in = '0;
			in_beat = 0;
			out_beat = 0;
			open_blocks = 0;
			test_errors = 0;
			beats_checked = 0;
			backpressure_cycles = 0;
			pass_count = 0;
			fail_count = 0;
		end
		else
		begin
			if (test_id == 3'd0 && (m_axis_tvalid || m_axis_tlast || s_axis_tready))
			begin
				$display("%s: a stream handshake output is high while the DUT is idle",
					test_name(test_id));
				test_errors++;
			end
			// Two unsent blocks occupy both banks
			if (open_blocks >= 2 && s_axis_tvalid)
			begin
				if (s_axis_tready)
				begin
					$display("%s: input accepted while both banks hold unsent blocks",
						test_name(test_id));
					test_errors++;
				end
				else
					backpressure_cycles++;
			end
			if (s_axis_tvalid && s_axis_tready)
			begin
				block_in[in_beat*tdata_width +: tdata_width] = strobe_mask(s_axis_tdata, s_axis_tstrb);
				in_beat++;
				if (s_axis_tlast || in_beat == beats_per_block)
				begin
					for (int j = 0; j < beats_per_block; j++)
						expected_q.push_back(transpose_beat(block_in, j));
					open_blocks++;
					block_in = '0;
					in_beat = 0;
				end
			end
			if (m_axis_tvalid && m_axis_tready)
			begin
				if (expected_q.size() == 0)
				begin
					$display("%s: output beat with no matching input block", test_name(test_id));
					test_errors++;
				end
				else
				begin
					expect_data = expected_q.pop_front();
					expect_last = (out_beat == beats_per_block - 1);
					beats_checked++;
					if (m_axis_tdata != expect_data)
					begin
						$display("ERR %s beat %0d: expected %h, actual %h", test_name(test_id),
							out_beat, expect_data, m_axis_tdata);
						test_errors++;
					end
					if (m_axis_tlast != expect_last)
					begin
						$display("ERR %s tlast on beat %0d: expected %b, actual %b",
							test_name(test_id), out_beat, expect_last, m_axis_tlast);
						test_errors++;
					end
				end
				out_beat++;
				if (out_beat == beats_per_block)
				begin
					out_beat = 0;
					open_blocks--;
				end
			end
			if (test_end)
			begin
				if (test_id == 3'd4 && backpressure_cycles == 0)
				begin
					$display("%s: input was never held back by full banks", test_name(test_id));
					test_errors++;
				end
				if (test_errors == 0)
				begin
					$display("%s: pass, %0d output beats checked", test_name(test_id), beats_checked);
					pass_count++;
				end
				else
				begin
					$display("%s: fail, %0d errors", test_name(test_id), test_errors);
					fail_count++;
				end
				test_errors = 0;
				beats_checked = 0;
				backpressure_cycles = 0;
			end
		end
		drained = (expected_q.size() == 0) && (in_beat == 0);
	end

endmodule

`default_nettype wire
